// ==== project.f ====
arb_pkg.sv
arb_rr.sv
arb_row_col.sv
arb_select.sv
arb_mux.sv
tb_arb_mux.sv

// ==== tb_arb_mux.sv ====
module tb_arb_mux
  import arb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TBL_LEN        = 40;
  localparam int          TIMEOUT_CYCLES = 16 + TBL_LEN + 20;
  localparam logic [31:0] SEED           = 32'h6ab8107a;

  localparam int K_IDLE = 0;
  localparam int K_ACT  = 1;
  localparam int K_PRE  = 2;
  localparam int K_COL  = 3;

  // Requests raised in one cycle plus the PHY credit return
  typedef struct packed {
    bm_vec_t row;
    bm_vec_t pre;
    bm_vec_t col;
    logic    credit;
  } stim_t;

  logic        clk = 1'b0;
  logic        rst_n;
  bm_vec_t     rts_row;
  bm_vec_t     rts_pre;
  bm_vec_t     rts_col;
  bm_req_arr_t bm_reqs;
  logic        cmd_credit;
  bm_vec_t     sending_row;
  bm_vec_t     sending_pre;
  bm_vec_t     sending_col;
  mc_bundle_t  mc_cmd;

  // Reference model state
  bm_vec_t     pend_row;
  bm_vec_t     pend_pre;
  bm_vec_t     pend_col;
  int          m_ptr_row;
  int          m_ptr_col;
  int          m_credits;
  int          m_last_act;
  mc_bundle_t  exp_mc;
  logic [31:0] rng;
  int unsigned cycle_cnt = 0;

  stim_t stim_tbl [TBL_LEN] = '{
    {4'h0, 4'h0, 4'h0, 1'b0},  // Idle after reset
    {4'h0, 4'h0, 4'h0, 1'b0},
    {4'h0, 4'h0, 4'h0, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b1},  // All machines want the column slot
    {4'h0, 4'h0, 4'hf, 1'b1},
    {4'h0, 4'h0, 4'hf, 1'b1},
    {4'h0, 4'h0, 4'hf, 1'b1},
    {4'h0, 4'h0, 4'hf, 1'b1},
    {4'h0, 4'h0, 4'hf, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},  // Drain
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h3, 4'h4, 4'h0, 1'b1},  // Two activates and a precharge
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h8, 4'h1, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h4, 4'h0, 4'h2, 1'b0},  // Row and column in one bundle
    {4'h1, 4'h0, 4'h8, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},  // Refill credits
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'hf, 1'b0},  // No returns until credits run out
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b0},
    {4'h0, 4'h0, 4'hf, 1'b1},  // Single credit back
    {4'h0, 4'h0, 4'h0, 1'b0},
    {4'h0, 4'h0, 4'h0, 1'b0},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1},
    {4'h0, 4'h0, 4'h0, 1'b1}
  };

  arb_mux u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .rts_row     (rts_row),
    .rts_pre     (rts_pre),
    .rts_col     (rts_col),
    .bm_reqs     (bm_reqs),
    .cmd_credit  (cmd_credit),
    .sending_row (sending_row),
    .sending_pre (sending_pre),
    .sending_col (sending_col),
    .mc_cmd      (mc_cmd)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the stimulus loop did not finish", cycle_cnt);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // First requester at or after ptr or -1 when none
  function automatic int rr_pick(input bm_vec_t req, input int ptr);
    int k;
    for (int i = 0; i < N_BANK_MACHS; i++) begin
      k = (ptr + i) % N_BANK_MACHS;
      if (req[k]) return k;
    end
    return -1;
  endfunction

  function automatic dram_cmd_t expect_cmd(input bm_req_t r, input int kind);
    dram_cmd_t c;
    c.cs_n    = '1;
    c.ras_n   = 1'b1;
    c.cas_n   = 1'b1;
    c.we_n    = 1'b1;
    c.bank    = '0;
    c.address = '0;
    if (kind != K_IDLE) begin
      c.cs_n = ~(RANKS'(1) << r.rank);  // Only the addressed rank selected
      c.bank = r.bank;
    end
    case (kind)
      K_ACT: begin
        c.ras_n   = 1'b0;
        c.address = r.row;
      end
      K_PRE: begin
        c.ras_n = 1'b0;
        c.we_n  = 1'b0;
      end
      K_COL: begin
        c.cas_n   = 1'b0;
        c.we_n    = ~r.wr;
        c.address = {{(ROW_WIDTH - COL_WIDTH){1'b0}}, r.col};
      end
      default: ;
    endcase
    return c;
  endfunction

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Raise new requests only on machines with nothing pending
  task automatic apply_stimulus(input int n);
    stim_t   s;
    bm_vec_t busy;
    bm_vec_t new_row;
    bm_vec_t new_pre;
    bm_vec_t new_col;
    s       = stim_tbl[n];
    busy    = pend_row | pend_pre | pend_col;
    new_pre = s.pre & ~busy;
    new_row = s.row & ~busy & ~s.pre;
    new_col = s.col & ~busy & ~s.row & ~s.pre;
    for (int i = 0; i < N_BANK_MACHS; i++) begin
      if (new_row[i] || new_pre[i] || new_col[i]) begin
        rng        = xorshift32(rng);
        bm_reqs[i] = bm_req_t'(rng[28:0]);
      end
    end
    pend_row   = pend_row | new_row;
    pend_pre   = pend_pre | new_pre;
    pend_col   = pend_col | new_col;
    rts_row    = pend_row;
    rts_pre    = pend_pre;
    rts_col    = pend_col;
    cmd_credit = s.credit && (m_credits < N_CREDITS);  // Never return unused credits
  endtask

  task automatic check_cycle(input int n);
    bm_vec_t    row_elig;
    bm_vec_t    col_elig;
    bm_vec_t    e_row;
    bm_vec_t    e_pre;
    bm_vec_t    e_col;
    int         rw;
    int         cw;
    mc_bundle_t nxt;
    check("mc_cmd.slot0", 64'(mc_cmd.slot0), 64'(exp_mc.slot0));
    check("mc_cmd.slot1", 64'(mc_cmd.slot1), 64'(exp_mc.slot1));
    row_elig = pend_pre;
    if (n - m_last_act >= T_RRD) row_elig = row_elig | pend_row;
    col_elig = pend_col;
    if (m_credits == 0) begin
      row_elig = '0;
      col_elig = '0;
    end
    rw        = rr_pick(row_elig, m_ptr_row);
    cw        = rr_pick(col_elig, m_ptr_col);
    e_row     = '0;
    e_pre     = '0;
    e_col     = '0;
    nxt.slot0 = expect_cmd('0, K_IDLE);
    nxt.slot1 = expect_cmd('0, K_IDLE);
    if (rw >= 0) begin
      if (pend_row[rw]) begin
        e_row[rw]  = 1'b1;
        nxt.slot0  = expect_cmd(bm_reqs[rw], K_ACT);
        m_last_act = n;
      end else begin
        e_pre[rw] = 1'b1;
        nxt.slot0 = expect_cmd(bm_reqs[rw], K_PRE);
      end
      m_ptr_row = (rw + 1) % N_BANK_MACHS;
    end
    if (cw >= 0) begin
      e_col[cw] = 1'b1;
      nxt.slot1 = expect_cmd(bm_reqs[cw], K_COL);
      m_ptr_col = (cw + 1) % N_BANK_MACHS;
    end
    check("sending_row", 64'(sending_row), 64'(e_row));
    check("sending_pre", 64'(sending_pre), 64'(e_pre));
    check("sending_col", 64'(sending_col), 64'(e_col));
    if (rw >= 0 || cw >= 0) m_credits--;  // One credit per bundle
    if (cmd_credit) m_credits++;
    pend_row = pend_row & ~e_row;
    pend_pre = pend_pre & ~e_pre;
    pend_col = pend_col & ~e_col;
    exp_mc   = nxt;
  endtask

  initial begin
    rst_n      = 1'b0;
    rts_row    = '0;
    rts_pre    = '0;
    rts_col    = '0;
    bm_reqs    = '0;
    cmd_credit = 1'b0;
    rng        = SEED;
    pend_row   = '0;
    pend_pre   = '0;
    pend_col   = '0;
    m_ptr_row  = 0;
    m_ptr_col  = 0;
    m_credits  = N_CREDITS;
    m_last_act = -T_RRD;
    exp_mc.slot0 = expect_cmd('0, K_IDLE);
    exp_mc.slot1 = expect_cmd('0, K_IDLE);
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    for (int n = 0; n < TBL_LEN; n++) begin
      @(posedge clk);
      #2;
      apply_stimulus(n);
      #26;  // Sample well before the next edge
      check_cycle(n);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== arb_mux.sv ====
module arb_mux
  import arb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  bm_vec_t     rts_row,
  input  bm_vec_t     rts_pre,
  input  bm_vec_t     rts_col,
  input  bm_req_arr_t bm_reqs,
  input  logic        cmd_credit,
  output bm_vec_t     sending_row,
  output bm_vec_t     sending_pre,
  output bm_vec_t     sending_col,
  output mc_bundle_t  mc_cmd
);

  // Arbitration, credits and tRRD
  arb_row_col arb_row_col0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rts_row     (rts_row),
    .rts_pre     (rts_pre),
    .rts_col     (rts_col),
    .cmd_credit  (cmd_credit),
    .sending_row (sending_row),
    .sending_pre (sending_pre),
    .sending_col (sending_col)
  );

  // Registered command bundle
  arb_select arb_select0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .bm_reqs     (bm_reqs),
    .sending_row (sending_row),
    .sending_pre (sending_pre),
    .sending_col (sending_col),
    .mc_cmd      (mc_cmd)
  );

endmodule

// ==== arb_select.sv ====
module arb_select
  import arb_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  bm_req_arr_t bm_reqs,
  input  bm_vec_t     sending_row,
  input  bm_vec_t     sending_pre,
  input  bm_vec_t     sending_col,
  output mc_bundle_t  mc_cmd
);

  bm_vec_t    row_sel;
  bm_req_t    row_req;
  bm_req_t    col_req;
  logic       row_valid;
  logic       col_valid;
  logic       is_pre;
  mc_bundle_t mc_cmd_d;

  // DDR pin encoding for one granted request
  function automatic dram_cmd_t encode_cmd(
    input bm_req_t req,
    input logic    row_slot,
    input logic    pre
  );
    dram_cmd_t cmd;
    cmd                = CMD_IDLE;
    cmd.cs_n[req.rank] = 1'b0;
    cmd.bank           = req.bank;
    if (row_slot) begin
      cmd.ras_n   = 1'b0;
      cmd.we_n    = !pre;                  // Low for precharge
      cmd.address = pre ? '0 : req.row;
    end else begin
      cmd.cas_n   = 1'b0;
      cmd.we_n    = !req.wr;
      cmd.address = row_addr_t'(req.col);  // Zero-extended column
    end
    return cmd;
  endfunction

  assign row_sel   = sending_row | sending_pre;
  assign row_valid = |row_sel;
  assign col_valid = |sending_col;
  assign is_pre    = |sending_pre;

  // AND-OR mux over the one-hot grants
  always_comb begin
    row_req = '0;
    col_req = '0;
    for (int i = 0; i < N_BANK_MACHS; i++) begin
      if (row_sel[i]) begin
        row_req = bm_req_t'(row_req | bm_reqs[i]);
      end
      if (sending_col[i]) begin
        col_req = bm_req_t'(col_req | bm_reqs[i]);
      end
    end
  end

  always_comb begin
    mc_cmd_d.slot0 = row_valid ? encode_cmd(row_req, 1'b1, is_pre) : CMD_IDLE;
    mc_cmd_d.slot1 = col_valid ? encode_cmd(col_req, 1'b0, 1'b0) : CMD_IDLE;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mc_cmd.slot0 <= CMD_IDLE;
      mc_cmd.slot1 <= CMD_IDLE;
    end else begin
      mc_cmd <= mc_cmd_d;
    end
  end

endmodule

// ==== arb_row_col.sv ====
module arb_row_col
  import arb_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  bm_vec_t rts_row,
  input  bm_vec_t rts_pre,
  input  bm_vec_t rts_col,
  input  logic    cmd_credit,
  output bm_vec_t sending_row,
  output bm_vec_t sending_pre,
  output bm_vec_t sending_col
);

  credit_cnt_t credit_cnt;
  rrd_timer_t  rrd_timer;
  logic        have_credit;
  logic        act_ok;
  logic        any_send;
  logic        act_sent;
  bm_vec_t     row_elig;
  bm_vec_t     col_elig;
  bm_vec_t     grant_row;
  bm_vec_t     grant_col;

  assign have_credit = (credit_cnt != '0);
  assign act_ok      = (rrd_timer == '0);

  // Activates wait for tRRD but precharges never do
  assign row_elig = (rts_pre | (act_ok ? rts_row : '0)) & {N_BANK_MACHS{have_credit}};
  assign col_elig = rts_col & {N_BANK_MACHS{have_credit}};

  arb_rr row_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (row_elig),
    .grant (grant_row)
  );

  arb_rr col_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (col_elig),
    .grant (grant_col)
  );

  assign sending_row = grant_row & rts_row;
  assign sending_pre = grant_row & rts_pre;
  assign sending_col = grant_col;

  assign act_sent = |sending_row;
  assign any_send = |{sending_row, sending_pre, sending_col};  // One credit per bundle

  // Next activate allowed T_RRD cycles after this one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rrd_timer <= '0;
    end else if (act_sent) begin
      rrd_timer <= rrd_timer_t'(T_RRD - 1);
    end else if (rrd_timer != '0) begin
      rrd_timer <= rrd_timer - 1'b1;
    end
  end

  // PHY command FIFO credits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= credit_cnt_t'(N_CREDITS);
    end else begin
      case ({any_send, cmd_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;  // Both or neither
      endcase
    end
  end

endmodule

// ==== arb_rr.sv ====
module arb_rr
  import arb_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  bm_vec_t req,
  output bm_vec_t grant
);

  bm_idx_t ptr;    // Highest priority requester
  bm_idx_t idx;
  bm_idx_t win;
  logic    found;

  // Scan from the pointer with wrap-around
  always_comb begin
    grant = '0;
    found = 1'b0;
    win   = ptr;
    idx   = ptr;
    for (int i = 0; i < N_BANK_MACHS; i++) begin
      idx = bm_idx_t'((int'(ptr) + i) % N_BANK_MACHS);
      if (!found && req[idx]) begin
        found      = 1'b1;
        win        = idx;
        grant[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= bm_idx_t'((int'(win) + 1) % N_BANK_MACHS);  // One past the winner
    end
  end

endmodule

// ==== arb_pkg.sv ====
package arb_pkg;

  localparam int N_BANK_MACHS = 4;
  localparam int N_CREDITS    = 4;  // PHY command FIFO depth
  localparam int T_RRD        = 2;  // Fabric cycles between activates

  localparam int ROW_WIDTH  = 14;
  localparam int COL_WIDTH  = 10;
  localparam int BANK_WIDTH = 3;
  localparam int RANK_WIDTH = 1;
  localparam int RANKS      = 2;

  localparam int BM_IDX_W    = (N_BANK_MACHS > 1) ? $clog2(N_BANK_MACHS) : 1;
  localparam int CREDIT_W    = $clog2(N_CREDITS + 1);
  localparam int RRD_TIMER_W = (T_RRD > 2) ? $clog2(T_RRD) : 1;

  typedef logic [N_BANK_MACHS-1:0] bm_vec_t;     // One bit per bank machine
  typedef logic [BM_IDX_W-1:0]     bm_idx_t;
  typedef logic [ROW_WIDTH-1:0]    row_addr_t;
  typedef logic [COL_WIDTH-1:0]    col_addr_t;
  typedef logic [BANK_WIDTH-1:0]   bank_addr_t;
  typedef logic [RANK_WIDTH-1:0]   rank_addr_t;
  typedef logic [CREDIT_W-1:0]     credit_cnt_t;
  typedef logic [RRD_TIMER_W-1:0]  rrd_timer_t;

  // Request as presented by one bank machine
  typedef struct packed {
    rank_addr_t rank;
    bank_addr_t bank;
    row_addr_t  row;
    col_addr_t  col;
    logic       wr;   // 1 for write
  } bm_req_t;

  typedef bm_req_t [N_BANK_MACHS-1:0] bm_req_arr_t;

  // One DDR command slot
  typedef struct packed {
    logic [RANKS-1:0] cs_n;
    logic             ras_n;
    logic             cas_n;
    logic             we_n;
    bank_addr_t       bank;
    row_addr_t        address;
  } dram_cmd_t;

  typedef struct packed {
    dram_cmd_t slot0;  // Row
    dram_cmd_t slot1;  // Column
  } mc_bundle_t;

  // Deselect with all pins high
  localparam dram_cmd_t CMD_IDLE = '{
    cs_n:    '1,
    ras_n:   1'b1,
    cas_n:   1'b1,
    we_n:    1'b1,
    bank:    '0,
    address: '0
  };

endpackage
